// File: energy_monitor.sv
// Ising energy accumulator over streamed coupling rows and the scaled bias vector
`timescale 1ns/10ps
`include "ising_settings.svh"

module energy_monitor
    import ising_pkg::*;
(
    input  logic                          clk_i,
    input  logic                          reset_i,
    input  logic                          flush_i,
    input  logic                          cand_valid_i,
    input  spin_t                         cand_spin_i,
    output logic                          cand_ready_o,
    input  logic                          row_valid_i,
    input  weight_word_t                  row_data_i,
    output logic                          row_ready_o,
    input  hbias_t                        hbias_i,
    input  logic [`ISING_SCALING_BIT-1:0] hscaling_i,
    output logic                          energy_valid_o,
    output energy_t                       energy_o,
    input  logic                          energy_ready_i
);

    localparam logic [1:0] ST_IDLE = 2'd0;
    localparam logic [1:0] ST_BUSY = 2'd1;
    localparam logic [1:0] ST_DONE = 2'd2;

    logic [1:0] state_q;
    spin_t      spin_q;
    waddr_t     word_cnt_q;
    energy_t    acc_q;
    energy_t    word_sum;
    logic       spin_hs;
    logic       row_hs;
    logic       last_word;

    // local field of one row, sum_j J_ij*s_j + scale*h_i
    function automatic energy_t row_field(
        input logic [`ISING_ROW_BIT-1:0]      row,
        input spin_t                          spin,
        input logic signed [`ISING_BITJ-1:0]  h,
        input logic [`ISING_SCALING_BIT-1:0]  scale
    );
        energy_t                            field;
        logic signed [`ISING_BITJ-1:0]      coupling;
        logic signed [`ISING_SCALING_BIT:0] scale_s;
        scale_s = {1'b0, scale};
        field = scale_s * h;
        for (int j = 0; j < `ISING_NUM_SPIN; j++) begin
            coupling = row[j*`ISING_BITJ +: `ISING_BITJ];
            if (spin[j]) begin
                field = field + coupling;
            end else begin
                field = field - coupling;
            end
        end
        return field;
    endfunction

    // contribution s_i * field_i of both rows in the current word
    always_comb begin
        int      row_idx;
        energy_t field;
        word_sum = '0;
        for (int p = 0; p < `ISING_PARALLELISM; p++) begin
            row_idx = int'(word_cnt_q) * `ISING_PARALLELISM + p;
            field = row_field(row_data_i[p*`ISING_ROW_BIT +: `ISING_ROW_BIT], spin_q,
                              hbias_i[row_idx*`ISING_BITJ +: `ISING_BITJ], hscaling_i);
            if (spin_q[row_idx]) begin
                word_sum = word_sum + field;
            end else begin
                word_sum = word_sum - field;
            end
        end
    end

    assign spin_hs        = cand_valid_i & cand_ready_o;
    assign row_hs         = row_valid_i & row_ready_o;
    assign last_word      = (word_cnt_q == waddr_t'(`ISING_WADDR_NUM - 1));
    assign cand_ready_o   = (state_q == ST_IDLE);
    assign row_ready_o    = (state_q == ST_BUSY);
    assign energy_valid_o = (state_q == ST_DONE);
    assign energy_o       = -acc_q;

    always_ff @(posedge clk_i) begin
        if (reset_i || flush_i) begin
            state_q    <= ST_IDLE;
            word_cnt_q <= '0;
        end else begin
            case (state_q)
                ST_IDLE: begin
                    if (spin_hs) begin
                        state_q    <= ST_BUSY;
                        word_cnt_q <= '0;
                    end
                end
                ST_BUSY: begin
                    if (row_hs) begin
                        word_cnt_q <= last_word ? '0 : word_cnt_q + 1'b1;
                        if (last_word) begin
                            state_q <= ST_DONE;
                        end
                    end
                end
                ST_DONE: begin
                    if (energy_ready_i) begin
                        state_q <= ST_IDLE;
                    end
                end
                default: begin
                    state_q <= ST_IDLE;
                end
            endcase
        end
    end

    // accumulator restarts with each new spin vector
    always_ff @(posedge clk_i) begin
        if (spin_hs) begin
            spin_q <= cand_spin_i;
            acc_q  <= '0;
        end else if (row_hs) begin
            acc_q <= acc_q + word_sum;
        end
    end

endmodule

// File: flip_manager.sv
// run control, flip-pattern reads, candidate generation and best-result tracking
`timescale 1ns/10ps
`include "ising_settings.svh"

module flip_manager
    import ising_pkg::*;
(
    input  logic        clk_i,
    input  logic        reset_i,
    input  logic        flush_i,
    input  logic        config_valid_i,
    input  spin_t       config_spin_initial_i,
    input  logic        cmpt_en_i,
    input  logic        en_comparison_i,
    input  logic        flip_disable_i,
    output logic        cmpt_idle_o,
    output logic        flip_ren_o,
    output flip_addr_t  flip_raddr_o,
    input  spin_t       flip_rdata_i,
    input  flip_count_t icon_count_i,
    output logic        cand_valid_o,
    output spin_t       cand_spin_o,
    input  logic        cand_ready_i,
    input  logic        energy_valid_i,
    input  energy_t     energy_i,
    output logic        energy_ready_o,
    output logic        energy_fifo_update_o,
    output logic        spin_fifo_update_o,
    output energy_t     energy_fifo_o,
    output spin_t       spin_fifo_o
);

    localparam logic [2:0] ST_IDLE = 3'd0;
    localparam logic [2:0] ST_SEND = 3'd1;
    localparam logic [2:0] ST_WAIT = 3'd2;
    localparam logic [2:0] ST_READ = 3'd3;
    localparam logic [2:0] ST_FLIP = 3'd4;

    logic [2:0]  state_q;
    logic        cmpt_en_q;
    logic        first_q;
    flip_count_t entry_q;
    spin_t       init_spin_q;
    spin_t       cand_q;
    energy_t     best_energy_q;
    spin_t       best_spin_q;
    logic        update_q;
    logic        start;
    logic        energy_hs;
    logic        accept;
    logic        last_entry;

    assign start      = cmpt_en_i & ~cmpt_en_q;
    assign energy_hs  = energy_valid_i & energy_ready_o;
    assign last_entry = (entry_q == icon_count_i);

    // initial spin always wins, later ones only if strictly lower when comparing
    assign accept = energy_hs & ~flush_i &
                    (first_q | ~en_comparison_i | (energy_i < best_energy_q));

    assign cmpt_idle_o          = (state_q == ST_IDLE);
    assign cand_valid_o         = (state_q == ST_SEND);
    assign cand_spin_o          = cand_q;
    assign energy_ready_o       = (state_q == ST_WAIT);
    assign flip_ren_o           = (state_q == ST_READ);
    assign flip_raddr_o         = entry_q[`ISING_FLIP_ADDR_BIT-1:0];
    assign energy_fifo_update_o = update_q;
    assign spin_fifo_update_o   = update_q;
    assign energy_fifo_o        = best_energy_q;
    assign spin_fifo_o          = best_spin_q;

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            cmpt_en_q <= 1'b0;
        end else begin
            cmpt_en_q <= cmpt_en_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (reset_i || flush_i) begin
            state_q <= ST_IDLE;
            first_q <= 1'b0;
            entry_q <= '0;
        end else begin
            case (state_q)
                ST_IDLE: begin
                    if (start) begin
                        state_q <= ST_SEND;
                        first_q <= 1'b1;
                        entry_q <= '0;
                    end
                end
                ST_SEND: begin
                    if (cand_ready_i) begin
                        state_q <= ST_WAIT;
                    end
                end
                ST_WAIT: begin
                    if (energy_hs) begin
                        first_q <= 1'b0;
                        state_q <= last_entry ? ST_IDLE : ST_READ;
                    end
                end
                ST_READ: begin
                    state_q <= ST_FLIP;
                end
                ST_FLIP: begin
                    entry_q <= entry_q + 1'b1;
                    state_q <= ST_SEND;
                end
                default: begin
                    state_q <= ST_IDLE;
                end
            endcase
        end
    end

    // best values move together with the update pulse
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            update_q      <= 1'b0;
            best_energy_q <= '0;
            best_spin_q   <= '0;
        end else begin
            update_q <= accept;
            if (accept) begin
                best_energy_q <= energy_i;
                best_spin_q   <= cand_q;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (config_valid_i) begin
            init_spin_q <= config_spin_initial_i;
        end
    end

    // flip data is valid in the cycle after the read strobe
    always_ff @(posedge clk_i) begin
        if (state_q == ST_IDLE && start) begin
            cand_q <= init_spin_q;
        end else if (state_q == ST_FLIP) begin
            cand_q <= flip_disable_i ? best_spin_q : (best_spin_q ^ flip_rdata_i);
        end
    end

endmodule

// File: ising_digital_core.sv
// digital compute core with weight fetcher, energy monitor and flip manager
`timescale 1ns/10ps
`include "ising_settings.svh"

module ising_digital_core
    import ising_pkg::*;
(
    input  logic                          clk_i,
    input  logic                          reset_i,
    input  logic                          flush_i,
    input  logic                          config_valid_fm_i,
    input  spin_t                         config_spin_initial_i,
    input  logic                          cmpt_en_i,
    input  logic                          en_comparison_i,
    input  logic                          flip_disable_i,
    output logic                          cmpt_idle_o,
    output logic                          flip_ren_o,
    output flip_addr_t                    flip_raddr_o,
    input  spin_t                         flip_rdata_i,
    input  flip_count_t                   icon_count_i,
    output logic                          dgt_weight_ren_o,
    output waddr_t                        dgt_weight_raddr_o,
    input  weight_word_t                  dgt_weight_i,
    input  hbias_t                        dgt_hbias_i,
    input  logic [`ISING_SCALING_BIT-1:0] dgt_hscaling_i,
    output logic                          energy_fifo_update_o,
    output logic                          spin_fifo_update_o,
    output energy_t                       energy_fifo_o,
    output spin_t                         spin_fifo_o
);

    // spin path
    logic         cand_valid;
    spin_t        cand_spin;
    logic         cand_ready;
    // energy path
    logic         energy_valid;
    energy_t      energy_value;
    logic         energy_ready;
    // weight path
    logic         row_valid;
    weight_word_t row_data;
    logic         row_ready;

    weight_fetch u_weight_fetch (
        .clk_i              (clk_i             ),
        .reset_i            (reset_i           ),
        .flush_i            (flush_i           ),
        .dgt_weight_ren_o   (dgt_weight_ren_o  ),
        .dgt_weight_raddr_o (dgt_weight_raddr_o),
        .dgt_weight_i       (dgt_weight_i      ),
        .row_valid_o        (row_valid         ),
        .row_data_o         (row_data          ),
        .row_ready_i        (row_ready         )
    );

    energy_monitor u_energy_monitor (
        .clk_i          (clk_i         ),
        .reset_i        (reset_i       ),
        .flush_i        (flush_i       ),
        .cand_valid_i   (cand_valid    ),
        .cand_spin_i    (cand_spin     ),
        .cand_ready_o   (cand_ready    ),
        .row_valid_i    (row_valid     ),
        .row_data_i     (row_data      ),
        .row_ready_o    (row_ready     ),
        .hbias_i        (dgt_hbias_i   ),
        .hscaling_i     (dgt_hscaling_i),
        .energy_valid_o (energy_valid  ),
        .energy_o       (energy_value  ),
        .energy_ready_i (energy_ready  )
    );

    flip_manager u_flip_manager (
        .clk_i                 (clk_i                ),
        .reset_i               (reset_i              ),
        .flush_i               (flush_i              ),
        .config_valid_i        (config_valid_fm_i    ),
        .config_spin_initial_i (config_spin_initial_i),
        .cmpt_en_i             (cmpt_en_i            ),
        .en_comparison_i       (en_comparison_i      ),
        .flip_disable_i        (flip_disable_i       ),
        .cmpt_idle_o           (cmpt_idle_o          ),
        .flip_ren_o            (flip_ren_o           ),
        .flip_raddr_o          (flip_raddr_o         ),
        .flip_rdata_i          (flip_rdata_i         ),
        .icon_count_i          (icon_count_i         ),
        .cand_valid_o          (cand_valid           ),
        .cand_spin_o           (cand_spin            ),
        .cand_ready_i          (cand_ready           ),
        .energy_valid_i        (energy_valid         ),
        .energy_i              (energy_value         ),
        .energy_ready_o        (energy_ready         ),
        .energy_fifo_update_o  (energy_fifo_update_o ),
        .spin_fifo_update_o    (spin_fifo_update_o   ),
        .energy_fifo_o         (energy_fifo_o        ),
        .spin_fifo_o           (spin_fifo_o          )
    );

endmodule

// File: ising_golden.txt
# name hbias scale init_spin icon_count en_cmp flip_dis exp_energy exp_spin exp_updates
# then 16 coupling rows J_i (hex, J_ij at nibble j) and 16 flip patterns (hex)
zero_flips 000000003E000001 3 0000 0 1 0 -2 0000 1
0000000000000030 0000000000000003 000000000000F000 0000000000000F00
0000000000200000 0000000000020000 0000000000000000 0000000000000000
0000000000000000 0000000000000000 0000000000000000 0000000000000000
0000000000000000 0000000000000000 0000000000000000 0000000000000000
FFFF FFFF FFFF FFFF FFFF FFFF FFFF FFFF FFFF FFFF FFFF FFFF FFFF FFFF FFFF FFFF
cmp_on 000000003E000001 2 0000 6 1 0 -24 0087 4
0000000000000030 0000000000000003 000000000000F000 0000000000000F00
0000000000200000 0000000000020000 0000000000000000 0000000000000000
0000000000000000 0000000000000000 0000000000000000 0000000000000000
0000000000000000 0000000000000000 0000000000000000 0000000000000000
0080 0040 0003 0004 0010 0100 FFFF FFFF FFFF FFFF FFFF FFFF FFFF FFFF FFFF FFFF
cmp_off 000000003E000001 2 0000 4 0 0 12 8071 5
0000000000000030 0000000000000003 000000000000F000 0000000000000F00
0000000000200000 0000000000020000 0000000000000000 0000000000000000
0000000000000000 0000000000000000 0000000000000000 0000000000000000
0000000000000000 0000000000000000 0000000000000000 0000000000000000
0040 0001 0030 8000 FFFF FFFF FFFF FFFF FFFF FFFF FFFF FFFF FFFF FFFF FFFF FFFF
flip_dis 000000003E000001 5 0055 3 0 1 28 0055 4
0000000000000030 0000000000000003 000000000000F000 0000000000000F00
0000000000200000 0000000000020000 0000000000000000 0000000000000000
0000000000000000 0000000000000000 0000000000000000 0000000000000000
0000000000000000 0000000000000000 0000000000000000 0000000000000000
00FF 1234 0001 FFFF FFFF FFFF FFFF FFFF FFFF FFFF FFFF FFFF FFFF FFFF FFFF FFFF

// File: ising_pkg.sv
// named vector types for spins, energies, weight words, bias and addresses
`include "ising_settings.svh"

package ising_pkg;

    // bit i set means spin i is +1
    typedef logic [`ISING_NUM_SPIN-1:0] spin_t;

    typedef logic signed [`ISING_ENERGY_BIT-1:0] energy_t;

    // row p at bit p*ROW_BIT, element j of a row at bit j*BITJ
    typedef logic [`ISING_PARALLELISM*`ISING_ROW_BIT-1:0] weight_word_t;

    // signed bias h_i in slice i
    typedef logic [`ISING_NUM_SPIN*`ISING_BITJ-1:0] hbias_t;

    typedef logic [`ISING_WADDR_BIT-1:0] waddr_t;

    typedef logic [`ISING_FLIP_ADDR_BIT-1:0] flip_addr_t;

    // one bit wider than the address, counts 0 to FLIP_DEPTH
    typedef logic [`ISING_FLIP_ADDR_BIT:0] flip_count_t;

endpackage

// File: ising_settings.svh
// constants for spin count, coupling format, parallelism and derived widths
`ifndef ISING_SETTINGS_SVH
`define ISING_SETTINGS_SVH

// spin array and coupling format
`define ISING_NUM_SPIN      16
`define ISING_BITJ          4
`define ISING_PARALLELISM   2
`define ISING_SCALING_BIT   4
`define ISING_ENERGY_BIT    32

// flip-pattern memory depth
`define ISING_FLIP_DEPTH    16

// weight words per spin vector
`define ISING_WADDR_NUM     (`ISING_NUM_SPIN / `ISING_PARALLELISM)

// one coupling row, NUM_SPIN elements of BITJ bits
`define ISING_ROW_BIT       (`ISING_NUM_SPIN * `ISING_BITJ)

// address widths
`define ISING_WADDR_BIT     ($clog2(`ISING_WADDR_NUM))
`define ISING_FLIP_ADDR_BIT ($clog2(`ISING_FLIP_DEPTH))

`endif

// File: ising_tb.sv
// testbench with golden-file reader, memory models, stimulus, result checks and watchdog
`timescale 1ns/10ps
`include "ising_settings.svh"

module ising_tb
    import ising_pkg::*;
();

    localparam int MAX_REC = 8;
    localparam int NSPIN   = `ISING_NUM_SPIN;
    localparam int DEPTH   = `ISING_FLIP_DEPTH;
    localparam int ROW     = `ISING_ROW_BIT;
    localparam int PAR     = `ISING_PARALLELISM;

    logic                          clk;
    logic                          reset_i;
    logic                          flush_i;
    logic                          config_valid_fm_i;
    spin_t                         config_spin_initial_i;
    logic                          cmpt_en_i;
    logic                          en_comparison_i;
    logic                          flip_disable_i;
    logic                          cmpt_idle_o;
    logic                          flip_ren_o;
    flip_addr_t                    flip_raddr_o;
    spin_t                         flip_rdata_i;
    flip_count_t                   icon_count_i;
    logic                          dgt_weight_ren_o;
    waddr_t                        dgt_weight_raddr_o;
    weight_word_t                  dgt_weight_i;
    hbias_t                        dgt_hbias_i;
    logic [`ISING_SCALING_BIT-1:0] dgt_hscaling_i;
    logic                          energy_fifo_update_o;
    logic                          spin_fifo_update_o;
    energy_t                       energy_fifo_o;
    spin_t                         spin_fifo_o;

    // golden records, J rows and flip patterns flattened per record
    logic [8*16-1:0]               rec_name [MAX_REC];
    hbias_t                        rec_h [MAX_REC];
    logic [`ISING_SCALING_BIT-1:0] rec_scale [MAX_REC];
    spin_t                         rec_init [MAX_REC];
    int                            rec_icon [MAX_REC];
    int                            rec_cmp [MAX_REC];
    int                            rec_dis [MAX_REC];
    int                            rec_energy [MAX_REC];
    spin_t                         rec_spin [MAX_REC];
    int                            rec_upd [MAX_REC];
    logic [ROW-1:0]                rec_j [MAX_REC*NSPIN];
    spin_t                         rec_flip [MAX_REC*DEPTH];

    int   num_rec;
    int   cur;
    int   upd_count;
    int   prev_energy;
    int   budget;
    logic mw_ren;
    int   mw_addr;
    logic mf_ren;
    int   mf_addr;

    tb_clock_gen u_clk (
        .clk_o (clk)
    );

    ising_digital_core uut (
        .clk_i                 (clk                  ),
        .reset_i               (reset_i              ),
        .flush_i               (flush_i              ),
        .config_valid_fm_i     (config_valid_fm_i    ),
        .config_spin_initial_i (config_spin_initial_i),
        .cmpt_en_i             (cmpt_en_i            ),
        .en_comparison_i       (en_comparison_i      ),
        .flip_disable_i        (flip_disable_i       ),
        .cmpt_idle_o           (cmpt_idle_o          ),
        .flip_ren_o            (flip_ren_o           ),
        .flip_raddr_o          (flip_raddr_o         ),
        .flip_rdata_i          (flip_rdata_i         ),
        .icon_count_i          (icon_count_i         ),
        .dgt_weight_ren_o      (dgt_weight_ren_o     ),
        .dgt_weight_raddr_o    (dgt_weight_raddr_o   ),
        .dgt_weight_i          (dgt_weight_i         ),
        .dgt_hbias_i           (dgt_hbias_i          ),
        .dgt_hscaling_i        (dgt_hscaling_i       ),
        .energy_fifo_update_o  (energy_fifo_update_o ),
        .spin_fifo_update_o    (spin_fifo_update_o   ),
        .energy_fifo_o         (energy_fifo_o        ),
        .spin_fifo_o           (spin_fifo_o          )
    );

    task automatic abort_run(input string why);
        $display("%0s", why);
        $display("*** FAILED ***");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_value(input string what, input int expected, input int actual);
        assert (actual == expected) else begin
            abort_run($sformatf("mismatch %0s %0s: expected %0d actual %0d",
                                rec_name[cur], what, expected, actual));
        end
    endtask

    // E = -sum_i s_i * (sum_j J_ij*s_j + scale*h_i), s = +1 or -1
    function automatic int calc_energy(input spin_t spin);
        int e;
        int field;
        int cpl;
        int hval;
        int sc;
        e = 0;
        sc = rec_scale[cur];
        for (int i = 0; i < NSPIN; i++) begin
            hval = $signed(rec_h[cur][i*`ISING_BITJ +: `ISING_BITJ]);
            field = sc * hval;
            for (int j = 0; j < NSPIN; j++) begin
                cpl = $signed(rec_j[cur*NSPIN + i][j*`ISING_BITJ +: `ISING_BITJ]);
                field = spin[j] ? field + cpl : field - cpl;
            end
            e = spin[i] ? e - field : e + field;
        end
        return e;
    endfunction

    task automatic load_golden();
        int                            fd;
        int                            code;
        logic [8*128-1:0]              line;
        logic [8*16-1:0]               t_name;
        hbias_t                        t_h;
        logic [`ISING_SCALING_BIT-1:0] t_scale;
        spin_t                         t_init;
        spin_t                         t_spin;
        spin_t                         t_flip;
        logic [ROW-1:0]                t_row;
        int                            t_icon;
        int                            t_cmp;
        int                            t_dis;
        int                            t_energy;
        int                            t_upd;
        fd = $fopen("ising_golden.txt", "r");
        assert (fd != 0) else abort_run("cannot open ising_golden.txt");
        // two column description lines
        code = $fgets(line, fd);
        code = $fgets(line, fd);
        num_rec = 0;
        while (num_rec < MAX_REC) begin
            code = $fscanf(fd, "%s %h %h %h %d %d %d %d %h %d", t_name, t_h, t_scale,
                           t_init, t_icon, t_cmp, t_dis, t_energy, t_spin, t_upd);
            if (code != 10) begin
                break;
            end
            rec_name[num_rec]   = t_name;
            rec_h[num_rec]      = t_h;
            rec_scale[num_rec]  = t_scale;
            rec_init[num_rec]   = t_init;
            rec_icon[num_rec]   = t_icon;
            rec_cmp[num_rec]    = t_cmp;
            rec_dis[num_rec]    = t_dis;
            rec_energy[num_rec] = t_energy;
            rec_spin[num_rec]   = t_spin;
            rec_upd[num_rec]    = t_upd;
            for (int i = 0; i < NSPIN; i++) begin
                code = $fscanf(fd, "%h", t_row);
                assert (code == 1) else abort_run("golden record has too few J rows");
                rec_j[num_rec*NSPIN + i] = t_row;
            end
            for (int k = 0; k < DEPTH; k++) begin
                code = $fscanf(fd, "%h", t_flip);
                assert (code == 1) else abort_run("golden record has too few flip patterns");
                rec_flip[num_rec*DEPTH + k] = t_flip;
            end
            num_rec++;
        end
        $fclose(fd);
        assert (num_rec > 0) else abort_run("no test records found in ising_golden.txt");
    endtask

    task automatic start_run();
        @(posedge clk);
        #1;
        config_valid_fm_i     = 1'b1;
        config_spin_initial_i = rec_init[cur];
        en_comparison_i       = (rec_cmp[cur] != 0);
        flip_disable_i        = (rec_dis[cur] != 0);
        icon_count_i          = flip_count_t'(rec_icon[cur]);
        dgt_hbias_i           = rec_h[cur];
        dgt_hscaling_i        = rec_scale[cur];
        upd_count             = 0;
        @(posedge clk);
        #1;
        config_valid_fm_i = 1'b0;
        cmpt_en_i         = 1'b1;
        @(posedge clk);
        #1;
        cmpt_en_i = 1'b0;
        @(negedge clk);
        assert (!cmpt_idle_o) else abort_run("run did not start after cmpt_en_i rose");
    endtask

    task automatic run_and_check();
        spin_t chain;
        start_run();
        while (!cmpt_idle_o) begin
            @(negedge clk);
        end
        // last update pulse shares the cycle where idle returns
        @(negedge clk);
        check_value("update count", rec_upd[cur], upd_count);
        check_value("best energy", rec_energy[cur], energy_fifo_o);
        check_value("best spin", rec_spin[cur], spin_fifo_o);
        if (rec_icon[cur] == 0) begin
            check_value("initial-spin energy", calc_energy(rec_init[cur]), energy_fifo_o);
            check_value("initial spin", rec_init[cur], spin_fifo_o);
        end
        if (rec_cmp[cur] == 0 && rec_dis[cur] == 0) begin
            chain = rec_init[cur];
            for (int k = 0; k < rec_icon[cur]; k++) begin
                chain = chain ^ rec_flip[cur*DEPTH + k];
            end
            check_value("accepted count", rec_icon[cur] + 1, upd_count);
            check_value("chained spin", chain, spin_fifo_o);
        end
    endtask

    // one-cycle flush pulse
    task automatic pulse_flush();
        @(posedge clk);
        #1 flush_i = 1'b1;
        @(posedge clk);
        #1 flush_i = 1'b0;
    endtask

    task automatic flush_mid_run();
        start_run();
        repeat (20) @(negedge clk);
        assert (!cmpt_idle_o) else abort_run("run finished before the flush point");
        pulse_flush();
        @(negedge clk);
        @(negedge clk);
        assert (cmpt_idle_o) else abort_run("cmpt_idle_o not high within two cycles of flush_i");
    endtask

    // weight and flip-pattern memories, one cycle read latency
    always begin
        @(negedge clk);
        mw_ren  = dgt_weight_ren_o;
        mw_addr = int'(dgt_weight_raddr_o);
        mf_ren  = flip_ren_o;
        mf_addr = int'(flip_raddr_o);
        @(posedge clk);
        #1;
        if (mw_ren === 1'b1) begin
            for (int p = 0; p < PAR; p++) begin
                dgt_weight_i[p*ROW +: ROW] = rec_j[cur*NSPIN + mw_addr*PAR + p];
            end
        end
        if (mf_ren === 1'b1) begin
            flip_rdata_i = rec_flip[cur*DEPTH + mf_addr];
        end
    end

    // every update pulse is checked as it happens
    always @(negedge clk) begin
        if (!reset_i) begin
            assert (energy_fifo_update_o == spin_fifo_update_o)
                else abort_run("energy and spin update pulses are not aligned");
            if (energy_fifo_update_o) begin
                check_value("pulse energy vs formula", calc_energy(spin_fifo_o), energy_fifo_o);
                if (rec_cmp[cur] != 0 && upd_count > 0) begin
                    assert (energy_fifo_o < prev_energy)
                        else abort_run($sformatf("accepted energy %0d is not below %0d",
                                                 energy_fifo_o, prev_energy));
                end
                if (rec_dis[cur] != 0) begin
                    check_value("disabled-flip energy", calc_energy(rec_init[cur]), energy_fifo_o);
                    check_value("disabled-flip spin", rec_init[cur], spin_fifo_o);
                end
                prev_energy = energy_fifo_o;
                upd_count++;
            end
        end
    end

    initial begin
        wait (budget > 0);
        repeat (budget) @(posedge clk);
        abort_run("timeout: the DUT did not finish within the cycle budget");
    end

    initial begin
        int total;
        reset_i               = 1'b1;
        flush_i               = 1'b0;
        config_valid_fm_i     = 1'b0;
        config_spin_initial_i = '0;
        cmpt_en_i             = 1'b0;
        en_comparison_i       = 1'b0;
        flip_disable_i        = 1'b0;
        flip_rdata_i          = '0;
        icon_count_i          = '0;
        dgt_weight_i          = '0;
        dgt_hbias_i           = '0;
        dgt_hscaling_i        = '0;
        cur                   = 0;
        upd_count             = 0;
        prev_energy           = 0;
        budget                = 0;
        repeat (8) @(posedge clk);
        #1 reset_i = 1'b0;
        @(negedge clk);
        assert (cmpt_idle_o === 1'b1 && flip_ren_o === 1'b0 && dgt_weight_ren_o === 1'b0 &&
                energy_fifo_update_o === 1'b0 && spin_fifo_update_o === 1'b0 &&
                energy_fifo_o === '0 && spin_fifo_o === '0)
            else abort_run("outputs are not in their reset state after reset");
        load_golden();
        // flushed records run three times
        total = 0;
        for (int r = 0; r < num_rec; r++) begin
            total += (rec_icon[r] + 1) * ((rec_icon[r] > 0) ? 3 : 1);
        end
        budget = 200 * total + 100;
        for (int r = 0; r < num_rec; r++) begin
            cur = r;
            // rows prefetched from the previous record's weights are dropped
            pulse_flush();
            run_and_check();
            if (rec_icon[r] > 0) begin
                flush_mid_run();
                run_and_check();
            end
        end
        $display("*** PASSED ***");
        $finish;
    end

endmodule

// File: list.f
+incdir+.
ising_pkg.sv
weight_fetch.sv
energy_monitor.sv
flip_manager.sv
ising_digital_core.sv
tb_clock_gen.sv
ising_tb.sv

// File: tb_clock_gen.sv
// clock source for the testbench, 8 ns period
`timescale 1ns/10ps

module tb_clock_gen (
    output logic clk_o
);

    localparam real HALF_PERIOD_NS = 4.0;

    initial begin
        clk_o = 1'b0;
        forever begin
            #(HALF_PERIOD_NS) clk_o = ~clk_o;
        end
    end

endmodule

// File: weight_fetch.sv
// weight memory read sequencer with a two-entry ready/valid row queue
`timescale 1ns/10ps
`include "ising_settings.svh"

module weight_fetch
    import ising_pkg::*;
(
    input  logic         clk_i,
    input  logic         reset_i,
    input  logic         flush_i,
    output logic         dgt_weight_ren_o,
    output waddr_t       dgt_weight_raddr_o,
    input  weight_word_t dgt_weight_i,
    output logic         row_valid_o,
    output weight_word_t row_data_o,
    input  logic         row_ready_i
);

    waddr_t       raddr_q;
    logic         inflight_q;
    weight_word_t queue_q [2];
    logic         wr_ptr_q;
    logic         rd_ptr_q;
    logic [1:0]   count_q;
    logic [2:0]   committed;
    logic         pop;
    logic         issue;

    assign pop = row_valid_o & row_ready_i;

    // stored words plus the word on its way back, minus the one leaving now
    assign committed = {1'b0, count_q} + {2'b00, inflight_q} - {2'b00, pop};

    // fetch while the monitor asks for rows and a slot stays free
    assign issue = row_ready_i & (committed < 3'd2);

    assign dgt_weight_ren_o   = issue;
    assign dgt_weight_raddr_o = raddr_q;
    assign row_valid_o        = (count_q != 2'd0);
    assign row_data_o         = queue_q[rd_ptr_q];

    always_ff @(posedge clk_i) begin
        if (reset_i || flush_i) begin
            raddr_q    <= '0;
            inflight_q <= 1'b0;
            wr_ptr_q   <= 1'b0;
            rd_ptr_q   <= 1'b0;
            count_q    <= 2'd0;
        end else begin
            inflight_q <= issue;
            if (issue) begin
                if (raddr_q == waddr_t'(`ISING_WADDR_NUM - 1)) begin
                    raddr_q <= '0;
                end else begin
                    raddr_q <= raddr_q + 1'b1;
                end
            end
            if (inflight_q) begin
                wr_ptr_q <= ~wr_ptr_q;
            end
            if (pop) begin
                rd_ptr_q <= ~rd_ptr_q;
            end
            count_q <= count_q + {1'b0, inflight_q} - {1'b0, pop};
        end
    end

    // read data lands one cycle after its strobe
    always_ff @(posedge clk_i) begin
        if (inflight_q) begin
            queue_q[wr_ptr_q] <= dgt_weight_i;
        end
    end

endmodule
